// File: piano_types_pkg.sv
package piano_types_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Notes and modes
    ////////////////////////////////////////////////////////////////////////////

    // 0 is rest, 1 to 7 are do to ti
    typedef logic [3:0] note_t;

    localparam note_t note_rest = 4'd0;

    // Mode encoding as on the board switches, unassigned codes act as off
    typedef enum logic [2:0] {
        mode_off         = 3'b000,
        mode_learn       = 3'b001,
        mode_auto        = 3'b010,
        mode_competition = 3'b011,
        mode_free        = 3'b100
    } mode_e;

    // What every engine presents and what leaves the top
    typedef struct packed {
        note_t       note;
        logic [1:0]  octave;
        logic [6:0]  led;
        logic [3:0]  num;
    } play_out_t;

    ////////////////////////////////////////////////////////////////////////////
    // Song table
    ////////////////////////////////////////////////////////////////////////////

    localparam int SONG_LEN = 16;

    typedef struct packed {
        note_t       note;
        logic [1:0]  octave;
    } song_entry_t;

    // Songs 0 to 2, song select 3 is silence
    localparam song_entry_t song_table [0:3][0:SONG_LEN-1] = '{
        '{'{4'd1, 2'd1}, '{4'd1, 2'd1}, '{4'd5, 2'd1}, '{4'd5, 2'd1},
          '{4'd6, 2'd1}, '{4'd6, 2'd1}, '{4'd5, 2'd1}, '{4'd0, 2'd0},
          '{4'd4, 2'd1}, '{4'd4, 2'd1}, '{4'd3, 2'd1}, '{4'd3, 2'd1},
          '{4'd2, 2'd1}, '{4'd2, 2'd1}, '{4'd1, 2'd1}, '{4'd0, 2'd0}},
        '{'{4'd3, 2'd1}, '{4'd3, 2'd1}, '{4'd4, 2'd1}, '{4'd5, 2'd1},
          '{4'd5, 2'd1}, '{4'd4, 2'd1}, '{4'd3, 2'd1}, '{4'd2, 2'd1},
          '{4'd1, 2'd1}, '{4'd1, 2'd1}, '{4'd2, 2'd1}, '{4'd3, 2'd1},
          '{4'd3, 2'd1}, '{4'd2, 2'd1}, '{4'd2, 2'd1}, '{4'd0, 2'd0}},
        '{'{4'd1, 2'd2}, '{4'd2, 2'd2}, '{4'd3, 2'd2}, '{4'd4, 2'd2},
          '{4'd5, 2'd2}, '{4'd6, 2'd2}, '{4'd7, 2'd2}, '{4'd0, 2'd0},
          '{4'd7, 2'd1}, '{4'd6, 2'd1}, '{4'd5, 2'd1}, '{4'd4, 2'd1},
          '{4'd3, 2'd1}, '{4'd2, 2'd1}, '{4'd1, 2'd1}, '{4'd0, 2'd0}},
        '{default: '0}
    };

    // One-hot LED pattern, bit n-1 for note n, zero for rest
    function automatic logic [6:0] note_led(note_t n);
        logic [6:0] led;
        led = '0;
        if (n >= 4'd1 && n <= 4'd7) begin
            led = 7'd1 << (n - 4'd1);
        end
        return led;
    endfunction

endpackage

// File: piano_cfg_pkg.sv
package piano_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // APB transport
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic         psel;
        logic         penable;
        logic         pwrite;
        logic [3:0]   paddr;
        logic [31:0]  pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0]  prdata;
        logic         pready;
        logic         pslverr;
    } apb_rsp_t;

    // Register map
    typedef enum logic [3:0] {
        reg_ctrl   = 4'h0,
        reg_play   = 4'h4,
        reg_status = 4'h8
    } reg_addr_e;

    ////////////////////////////////////////////////////////////////////////////
    // Configuration seen by the engines
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        piano_types_pkg::mode_e  mode;
        logic [1:0]              song;
        logic [1:0]              speed;
        logic [1:0]              octave;
        logic                    play;
    } cfg_t;

endpackage

// File: piano_regs.sv
`timescale 1ns/10ps

module piano_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  piano_cfg_pkg::apb_req_t apb_req,
    output piano_cfg_pkg::apb_rsp_t apb_rsp,
    output piano_cfg_pkg::cfg_t     cfg,
    input  logic [3:0]              status_num,
    input  logic [3:0]              status_score
);
    import piano_types_pkg::*;
    import piano_cfg_pkg::*;

    logic access;
    logic ctrl_sel;
    logic play_sel;
    logic status_sel;
    logic bad_access;
    logic wr_ctrl;
    logic wr_play;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // Transfer only in the access phase
        access     = apb_req.psel && apb_req.penable;
        ctrl_sel   = apb_req.paddr == reg_ctrl;
        play_sel   = apb_req.paddr == reg_play;
        status_sel = apb_req.paddr == reg_status;
        // Unknown address, or STATUS written
        bad_access = access && (!(ctrl_sel || play_sel || status_sel)
                                || (apb_req.pwrite && status_sel));
        wr_ctrl    = access && apb_req.pwrite && ctrl_sel;
        wr_play    = access && apb_req.pwrite && play_sel;
    end

    // No wait states, read data valid during access
    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = bad_access;
        apb_rsp.prdata  = '0;
        if (ctrl_sel) begin
            // mode 2:0, song 4:3, speed 6:5, octave 8:7
            apb_rsp.prdata = {23'd0, cfg.octave, cfg.speed, cfg.song, cfg.mode};
        end else if (play_sel) begin
            apb_rsp.prdata = {31'd0, cfg.play};
        end else if (status_sel) begin
            apb_rsp.prdata = {24'd0, status_score, status_num};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Configuration and play flag
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset) begin
            // All zero means mode_off and stopped
            cfg <= '0;
        end else begin
            if (wr_ctrl) begin
                cfg.mode   <= mode_e'(apb_req.pwdata[2:0]);
                cfg.song   <= apb_req.pwdata[4:3];
                cfg.speed  <= apb_req.pwdata[6:5];
                cfg.octave <= apb_req.pwdata[8:7];
            end
            // Start write flips play
            if (wr_play && apb_req.pwdata[0]) begin
                cfg.play <= ~cfg.play;
            end
        end
    end

endmodule

// File: song_sequencer.sv
`timescale 1ns/10ps

module song_sequencer #(
    parameter int BEAT_CYCLES = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  piano_cfg_pkg::cfg_t        cfg,
    input  logic [6:0]                 keys,
    output piano_types_pkg::play_out_t seq_out,
    output logic [3:0]                 score
);
    import piano_types_pkg::*;

    // Longest slot is four beats at speed 3
    localparam int TIMER_W = $clog2(BEAT_CYCLES * 4 + 1);

    typedef enum logic {
        seq_idle,
        seq_play
    } seq_state_e;

    seq_state_e          state;
    logic [3:0]          pos;
    logic [TIMER_W-1:0]  timer;
    logic [TIMER_W-1:0]  slot_last;
    logic                hit;
    logic                active;
    logic                slot_end;
    logic                key_hit;
    song_entry_t         entry;

    always_comb begin
        active    = cfg.play && (cfg.mode == mode_auto || cfg.mode == mode_competition);
        // Slot length BEAT_CYCLES * (speed + 1)
        slot_last = TIMER_W'(BEAT_CYCLES * (int'(cfg.speed) + 1) - 1);
        slot_end  = timer >= slot_last;
        entry     = song_table[cfg.song][pos];
        // First matching press of a sounding note, competition only
        key_hit   = (cfg.mode == mode_competition) && !hit
                    && (entry.note != note_rest) && (keys == note_led(entry.note));
    end

    ////////////////////////////////////////////////////////////////////////////
    // Beat timer, position and score
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset || !active) begin
            // Stopped or other mode, everything back to the start
            state <= seq_idle;
            pos   <= '0;
            timer <= '0;
            hit   <= 1'b0;
            score <= '0;
        end else begin
            state <= seq_play;
            if (state == seq_play) begin
                if (key_hit) begin
                    hit <= 1'b1;
                    // Saturate at 15
                    if (score != 4'hf) begin
                        score <= score + 4'd1;
                    end
                end
                if (slot_end) begin
                    timer <= '0;
                    hit   <= 1'b0;
                    pos   <= (pos == 4'(SONG_LEN - 1)) ? 4'd0 : pos + 4'd1;
                end else begin
                    timer <= timer + 1'b1;
                end
            end
        end
    end

    // Silent until the first slot starts
    always_comb begin
        seq_out = '0;
        if (state == seq_play) begin
            seq_out.note   = entry.note;
            seq_out.octave = entry.octave;
            seq_out.led    = note_led(entry.note);
            seq_out.num    = pos;
        end
    end

endmodule

// File: learn_tracker.sv
`timescale 1ns/10ps

module learn_tracker (
    input  logic                       clk,
    input  logic                       reset,
    input  piano_cfg_pkg::cfg_t        cfg,
    input  logic [6:0]                 keys,
    output piano_types_pkg::play_out_t learn_out
);
    import piano_types_pkg::*;

    typedef enum logic {
        lrn_wait_key,
        lrn_wait_release
    } lrn_state_e;

    lrn_state_e   state;
    logic [3:0]   pos;
    logic         match;
    song_entry_t  entry;

    always_comb begin
        entry = song_table[cfg.song][pos];
        // A rest needs no key
        match = (keys == note_led(entry.note)) || (entry.note == note_rest);
    end

    always_ff @(posedge clk) begin
        if (!reset || cfg.mode != mode_learn) begin
            state <= lrn_wait_key;
            pos   <= '0;
        end else begin
            case (state)
                lrn_wait_key: begin
                    if (match) begin
                        pos   <= (pos == 4'(SONG_LEN - 1)) ? 4'd0 : pos + 4'd1;
                        state <= lrn_wait_release;
                    end
                end
                default: begin
                    // Hands off the keys before the next note counts
                    if (keys == '0) begin
                        state <= lrn_wait_key;
                    end
                end
            endcase
        end
    end

    // Current note shown on the LEDs
    always_comb begin
        learn_out.note   = entry.note;
        learn_out.octave = entry.octave;
        learn_out.led    = note_led(entry.note);
        learn_out.num    = pos;
    end

endmodule

// File: mode_controller.sv
`timescale 1ns/10ps

module mode_controller (
    input  logic                       clk,
    input  logic                       reset,
    input  piano_cfg_pkg::cfg_t        cfg,
    input  logic [6:0]                 keys,
    input  piano_types_pkg::play_out_t seq_out,
    input  logic [3:0]                 seq_score,
    input  piano_types_pkg::play_out_t learn_out,
    output piano_types_pkg::play_out_t play_out,
    output logic [3:0]                 score
);
    import piano_types_pkg::*;

    play_out_t   next_out;
    logic [3:0]  next_score;

    // Lowest pressed key wins, rest when nothing is down
    function automatic note_t lowest_key(logic [6:0] k);
        note_t n;
        n = note_rest;
        for (int i = 6; i >= 0; i--) begin
            if (k[i]) begin
                n = note_t'(i + 1);
            end
        end
        return n;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Per-mode source select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        next_out = '0;
        case (cfg.mode)
            mode_free: begin
                // Keys play directly at the configured octave
                next_out.note   = lowest_key(keys);
                next_out.octave = cfg.octave;
                next_out.led    = keys;
                next_out.num    = '0;
            end
            mode_auto, mode_competition: begin
                next_out = seq_out;
            end
            mode_learn: begin
                next_out = learn_out;
            end
            default: begin
                // Off and unassigned codes stay silent
                next_out = '0;
            end
        endcase
        // Score only shown while competing
        next_score = (cfg.mode == mode_competition) ? seq_score : 4'd0;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            play_out <= '0;
            score    <= '0;
        end else begin
            play_out <= next_out;
            score    <= next_score;
        end
    end

endmodule

// File: piano_top.sv
`timescale 1ns/10ps

module piano_top #(
    parameter int BEAT_CYCLES = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  piano_cfg_pkg::apb_req_t    apb_req,
    output piano_cfg_pkg::apb_rsp_t    apb_rsp,
    input  logic [6:0]                 keys,
    output piano_types_pkg::play_out_t play_out,
    output logic [3:0]                 score
);
    import piano_types_pkg::*;
    import piano_cfg_pkg::*;

    cfg_t        cfg;
    play_out_t   seq_out;
    play_out_t   learn_out;
    logic [3:0]  seq_score;

    // Register block, STATUS reads the selected outputs
    piano_regs piano_regs_inst (
        .clk          (clk),
        .reset        (reset),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .cfg          (cfg),
        .status_num   (play_out.num),
        .status_score (score)
    );

    // Auto and competition share one sequencer
    song_sequencer #(
        .BEAT_CYCLES (BEAT_CYCLES)
    ) song_sequencer_inst (
        .clk     (clk),
        .reset   (reset),
        .cfg     (cfg),
        .keys    (keys),
        .seq_out (seq_out),
        .score   (seq_score)
    );

    learn_tracker learn_tracker_inst (
        .clk       (clk),
        .reset     (reset),
        .cfg       (cfg),
        .keys      (keys),
        .learn_out (learn_out)
    );

    mode_controller mode_controller_inst (
        .clk       (clk),
        .reset     (reset),
        .cfg       (cfg),
        .keys      (keys),
        .seq_out   (seq_out),
        .seq_score (seq_score),
        .learn_out (learn_out),
        .play_out  (play_out),
        .score     (score)
    );

endmodule

// File: piano_checker.sv
`timescale 1ns/10ps

module piano_checker #(
    parameter int BEAT_CYCLES = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  piano_cfg_pkg::apb_req_t    apb_req,
    input  piano_cfg_pkg::apb_rsp_t    apb_rsp,
    input  logic [6:0]                 keys,
    input  piano_types_pkg::play_out_t play_out,
    input  logic [3:0]                 score,
    output int                         error_count
);
    import piano_types_pkg::*;
    import piano_cfg_pkg::*;

    int errors = 0;

    // Register model
    logic [2:0]   m_mode;
    logic [1:0]   m_song;
    logic [1:0]   m_speed;
    logic [1:0]   m_octave;
    logic         m_play;

    // Sequencer model
    logic         s_running;
    int           s_pos;
    int           s_elapsed;
    logic         s_hit;
    int           s_score;

    // Learn model, armed means waiting for a press
    logic         l_armed;
    int           l_pos;

    // What the DUT outputs should show now
    play_out_t    m_out;
    int           m_score;

    // Values seen just before the edge
    logic         seq_active;
    play_out_t    seq_view;
    play_out_t    learn_view;
    play_out_t    sel_next;
    int           score_next;
    song_entry_t  entry;
    logic         access;
    logic         bad_access;

    assign error_count = errors;

    function automatic logic [6:0] led_of(note_t n);
        logic [6:0] led;
        led = 7'd0;
        for (int i = 1; i <= 7; i++) begin
            if (n == note_t'(i)) begin
                led[i-1] = 1'b1;
            end
        end
        return led;
    endfunction

    // Free mode plays the lowest key held
    function automatic note_t key_note(logic [6:0] k);
        note_t n;
        n = 4'd0;
        for (int i = 0; i < 7; i++) begin
            if (k[i] && n == 4'd0) begin
                n = note_t'(i + 1);
            end
        end
        return n;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("error t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks on the pre-edge values
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_outputs();
        compare_field("play_out.note", 32'(m_out.note), 32'(play_out.note));
        compare_field("play_out.octave", 32'(m_out.octave), 32'(play_out.octave));
        compare_field("play_out.led", 32'(m_out.led), 32'(play_out.led));
        compare_field("play_out.num", 32'(m_out.num), 32'(play_out.num));
        compare_field("score", 32'(m_score), 32'(score));
    endtask

    task automatic check_apb();
        access     = apb_req.psel && apb_req.penable;
        bad_access = 1'b0;
        if (access) begin
            bad_access = !(apb_req.paddr == reg_ctrl || apb_req.paddr == reg_play
                           || apb_req.paddr == reg_status)
                         || (apb_req.pwrite && apb_req.paddr == reg_status);
            compare_field("apb_rsp.pready", 32'd1, 32'(apb_rsp.pready));
            compare_field("apb_rsp.pslverr", 32'(bad_access), 32'(apb_rsp.pslverr));
            if (!bad_access && !apb_req.pwrite) begin
                case (apb_req.paddr)
                    reg_ctrl: begin
                        compare_field("apb_rsp.prdata", 32'(m_mode) | (32'(m_song) << 3)
                                      | (32'(m_speed) << 5) | (32'(m_octave) << 7),
                                      apb_rsp.prdata);
                    end
                    reg_play: begin
                        compare_field("apb_rsp.prdata", 32'(m_play), apb_rsp.prdata);
                    end
                    default: begin
                        // STATUS mirrors the visible num and score
                        compare_field("apb_rsp.prdata",
                                      32'(m_out.num) | (32'(m_score) << 4), apb_rsp.prdata);
                    end
                endcase
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Model step
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_views();
        seq_active = m_play && (m_mode == mode_auto || m_mode == mode_competition);
        seq_view   = '0;
        // Silent on the first active cycle
        if (s_running) begin
            entry           = song_table[m_song][s_pos];
            seq_view.note   = entry.note;
            seq_view.octave = entry.octave;
            seq_view.led    = led_of(entry.note);
            seq_view.num    = 4'(s_pos);
        end
        entry             = song_table[m_song][l_pos];
        learn_view.note   = entry.note;
        learn_view.octave = entry.octave;
        learn_view.led    = led_of(entry.note);
        learn_view.num    = 4'(l_pos);
        sel_next = '0;
        if (m_mode == mode_free) begin
            sel_next.note   = key_note(keys);
            sel_next.octave = m_octave;
            sel_next.led    = keys;
        end else if (m_mode == mode_auto || m_mode == mode_competition) begin
            sel_next = seq_view;
        end else if (m_mode == mode_learn) begin
            sel_next = learn_view;
        end
        score_next = (m_mode == mode_competition) ? s_score : 0;
    endtask

    task automatic step_sequencer();
        if (!seq_active) begin
            s_running = 1'b0;
            s_pos     = 0;
            s_elapsed = 0;
            s_hit     = 1'b0;
            s_score   = 0;
        end else if (!s_running) begin
            s_running = 1'b1;
        end else begin
            // First matching press of a sounding note
            if (m_mode == mode_competition && !s_hit && seq_view.note != 4'd0
                && keys == seq_view.led) begin
                s_hit = 1'b1;
                if (s_score < 15) begin
                    s_score++;
                end
            end
            if (s_elapsed + 1 >= BEAT_CYCLES * (int'(m_speed) + 1)) begin
                s_elapsed = 0;
                s_hit     = 1'b0;
                s_pos     = (s_pos + 1) % SONG_LEN;
            end else begin
                s_elapsed++;
            end
        end
    endtask

    task automatic step_learn();
        if (m_mode != mode_learn) begin
            l_armed = 1'b1;
            l_pos   = 0;
        end else if (l_armed) begin
            if (learn_view.note == 4'd0 || keys == learn_view.led) begin
                l_pos   = (l_pos + 1) % SONG_LEN;
                l_armed = 1'b0;
            end
        end else if (keys == 7'd0) begin
            l_armed = 1'b1;
        end
    endtask

    task automatic step_registers();
        if (access && apb_req.pwrite && !bad_access) begin
            if (apb_req.paddr == reg_ctrl) begin
                m_mode   = apb_req.pwdata[2:0];
                m_song   = apb_req.pwdata[4:3];
                m_speed  = apb_req.pwdata[6:5];
                m_octave = apb_req.pwdata[8:7];
            end else if (apb_req.paddr == reg_play && apb_req.pwdata[0]) begin
                m_play = !m_play;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            m_mode    = 3'd0;
            m_song    = 2'd0;
            m_speed   = 2'd0;
            m_octave  = 2'd0;
            m_play    = 1'b0;
            s_running = 1'b0;
            s_pos     = 0;
            s_elapsed = 0;
            s_hit     = 1'b0;
            s_score   = 0;
            l_armed   = 1'b1;
            l_pos     = 0;
            m_out     = '0;
            m_score   = 0;
            access    = 1'b0;
        end else begin
            check_outputs();
            check_apb();
            // Engines see the old configuration, registers update last
            build_views();
            step_sequencer();
            step_learn();
            m_out   = sel_next;
            m_score = score_next;
            step_registers();
        end
    end

endmodule

// File: tb_piano.sv
`timescale 1ns/10ps

module tb_piano;
    import piano_types_pkg::*;
    import piano_cfg_pkg::*;

    localparam int BEAT_CYCLES = 8;
    // Longest song pass is 16 slots of 32 cycles
    localparam int WAIT_LIMIT = 2000;

    logic        clk;
    logic        reset;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [6:0]  keys;
    play_out_t   play_out;
    logic [3:0]  score;
    int          checker_errors;
    int          timeouts;

    // 4 ns period
    always #2 clk = ~clk;

    piano_top #(
        .BEAT_CYCLES (BEAT_CYCLES)
    ) piano_top_inst (
        .clk      (clk),
        .reset    (reset),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .keys     (keys),
        .play_out (play_out),
        .score    (score)
    );

    piano_checker #(
        .BEAT_CYCLES (BEAT_CYCLES)
    ) piano_checker_inst (
        .clk         (clk),
        .reset       (reset),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .keys        (keys),
        .play_out    (play_out),
        .score       (score),
        .error_count (checker_errors)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers, all return just after a falling edge
    ////////////////////////////////////////////////////////////////////////////

    // Key pattern a player presses for a note
    function automatic logic [6:0] pattern_of(note_t n);
        logic [6:0] p;
        p = 7'd0;
        if (n >= 4'd1 && n <= 4'd7) begin
            p = 7'(7'd1 << (n - 4'd1));
        end
        return p;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Setup phase, then access phase until pready
    task automatic apb_access(input logic write, input logic [3:0] addr,
                              input logic [31:0] data);
        int waited;
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(negedge clk);
        apb_req.penable = 1'b1;
        waited = 0;
        @(posedge clk);
        while (!apb_rsp.pready && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clk);
        end
        if (!apb_rsp.pready) begin
            timeouts++;
            $display("timeout: APB access to address %0h never got pready", addr);
        end
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic write_ctrl(input logic [2:0] mode, input logic [1:0] song,
                              input logic [1:0] speed, input logic [1:0] octave);
        apb_access(1'b1, reg_ctrl, {23'd0, octave, speed, song, mode});
    endtask

    // Start write, bit 0 flips play
    task automatic toggle_play();
        apb_access(1'b1, reg_play, 32'd1);
    endtask

    task automatic wait_num(input logic [3:0] target);
        int waited;
        waited = 0;
        @(negedge clk);
        while (play_out.num != target && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (play_out.num != target) begin
            timeouts++;
            $display("timeout: play_out.num never reached %0d", target);
        end
    endtask

    task automatic wait_num_change(input logic [3:0] old_num);
        int waited;
        waited = 0;
        @(negedge clk);
        while (play_out.num == old_num && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (play_out.num == old_num) begin
            timeouts++;
            $display("timeout: play_out.num stuck at %0d", old_num);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [2:0]  sel_mode;
        logic [1:0]  song;
        logic [1:0]  speed;
        logic [3:0]  addr;
        logic [3:0]  start_num;
        logic [6:0]  right;
        logic [6:0]  wrong;
        note_t       note;

        clk      = 1'b0;
        reset    = 1'b0;
        apb_req  = '0;
        keys     = '0;
        timeouts = 0;
        void'($urandom(32'h2f33_60ce));

        // Reset low for ten cycles
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        wait_cycles(2);
        apb_access(1'b0, reg_play, 32'd0);

        // CTRL write and read back
        for (int i = 0; i < 8; i++) begin
            write_ctrl(3'($urandom()), 2'($urandom()), 2'($urandom()), 2'($urandom()));
            apb_access(1'b0, reg_ctrl, 32'd0);
        end
        // STATUS is read only
        apb_access(1'b1, reg_status, $urandom());
        apb_access(1'b0, reg_ctrl, 32'd0);
        // Holes in the map
        for (int i = 0; i < 4; i++) begin
            addr = 4'($urandom());
            if (addr == reg_ctrl || addr == reg_play || addr == reg_status) begin
                addr = addr + 4'd2;
            end
            apb_access(1'b1, addr, $urandom());
            apb_access(1'b0, addr, 32'd0);
            apb_access(1'b0, reg_ctrl, 32'd0);
        end

        // Free play
        write_ctrl(mode_free, 2'd0, 2'd0, 2'($urandom()));
        for (int i = 0; i < 24; i++) begin
            keys = 7'($urandom());
            wait_cycles(3);
        end
        keys = '0;

        // Auto play, one full pass then stop mid song
        song  = 2'($urandom());
        speed = 2'($urandom());
        write_ctrl(mode_auto, song, speed, 2'($urandom()));
        toggle_play();
        wait_num(4'd15);
        wait_num(4'd0);
        wait_num(4'd4);
        toggle_play();
        wait_num(4'd0);

        // Learn mode
        song = 2'($urandom_range(0, 2));
        write_ctrl(mode_learn, song, 2'($urandom()), 2'($urandom()));
        wait_cycles(3);
        for (int step = 0; step < 20; step++) begin
            start_num = play_out.num;
            note      = song_table[song][start_num].note;
            if (note == note_rest) begin
                // Rests move on without a key
                wait_num_change(start_num);
                wait_cycles(2);
            end else begin
                right = pattern_of(note);
                for (int t = 0; t < 3; t++) begin
                    wrong = 7'($urandom());
                    if (wrong == right) begin
                        wrong = wrong ^ 7'h01;
                    end
                    keys = wrong;
                    wait_cycles(2);
                end
                keys = right;
                wait_num_change(start_num);
                keys = '0;
                wait_cycles(3);
            end
        end

        // Competition with random hits and misses
        song  = 2'($urandom_range(0, 2));
        speed = 2'($urandom());
        write_ctrl(mode_competition, song, speed, 2'($urandom()));
        toggle_play();
        for (int c = 0; c < 800; c++) begin
            if ($urandom_range(0, 3) == 0) begin
                keys = 7'($urandom());
            end else if ($urandom_range(0, 1) == 0) begin
                keys = pattern_of(play_out.note);
            end else begin
                keys = '0;
            end
            wait_cycles(1);
        end
        for (int i = 0; i < 3; i++) begin
            apb_access(1'b0, reg_status, 32'd0);
        end
        keys = '0;
        toggle_play();
        wait_num(4'd0);

        // Unassigned mode codes, play on as well
        toggle_play();
        for (int m = 5; m < 9; m++) begin
            sel_mode = 3'(m);
            write_ctrl(sel_mode, 2'($urandom()), 2'($urandom()), 2'($urandom()));
            for (int i = 0; i < 6; i++) begin
                keys = 7'($urandom());
                wait_cycles(2);
            end
        end
        toggle_play();

        keys = '0;
        wait_cycles(5);
        $display("errors: %0d compare, %0d timeout", checker_errors, timeouts);
        if (checker_errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
piano_types_pkg.sv
piano_cfg_pkg.sv
piano_regs.sv
song_sequencer.sv
learn_tracker.sv
mode_controller.sv
piano_top.sv
piano_checker.sv
tb_piano.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_piano -f flist.f

result=$(./obj_dir/Vtb_piano)
echo "$result"

if echo "$result" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1
